//--- filelist.f
common/bank_pkg.sv
common/msg_pkg.sv
logic/slot_alloc.sv
logic/entry_ram.sv
list/list_ctrl.sv
list/out_buf.sv
logic/msg_bank_top.sv
tb/msg_bank_props.sv
tb/tb_msg_bank.sv

//--- Makefile
# Verilator simulation of the message bank

VERILATOR ?= verilator
TOP       ?= tb_msg_bank
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Run reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_msg_bank.sv
// ----------------------------------------------------------
// Testbench for the message bank: clock, reset, seeded random
// stimulus, per-ID queue model, output checks and watchdog
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_msg_bank;

  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 5;
  localparam int NumCycles   = 2000;
  localparam int TimeoutNs   = (NumCycles + 100) * ClkPeriod;

  logic                                     clk_i;
  logic                                     rst_ni;
  logic                                     in_valid_i;
  msg_pkg::msg_in_t                         in_msg_i;
  logic                                     in_ready_o;
  logic                                     release_valid_i;
  bank_pkg::id_t                            release_id_i;
  logic [bank_pkg::NumIds-1:0]              buf_valid_o;
  msg_pkg::payload_t [bank_pkg::NumIds-1:0] buf_data_o;

  integer seed = 76381;
  int     errors;
  int     checks;
  int     ram_pops;
  int     full_seen;
  int     same_cycle [3];

  // One FIFO per ID; the front is what the buffer must show
  msg_pkg::payload_t model_q [bank_pkg::NumIds][$];

  // Copies of the inputs that are applied during the current cycle
  logic              drv_in_valid;
  bank_pkg::id_t     drv_id;
  msg_pkg::payload_t drv_payload;
  logic              drv_rel_valid;
  bank_pkg::id_t     drv_rel_id;

  msg_bank_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_valid_i      (in_valid_i),
    .in_msg_i        (in_msg_i),
    .in_ready_o      (in_ready_o),
    .release_valid_i (release_valid_i),
    .release_id_i    (release_id_i),
    .buf_valid_o     (buf_valid_o),
    .buf_data_o      (buf_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("Mismatch %s exp %h got %h", name, exp, got);
    end
  endtask

  // Every message beyond the one in its buffer takes a RAM entry
  function automatic logic model_ready();
    int used;
    used = 0;
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      if (model_q[i].size() > 1) begin
        used += model_q[i].size() - 1;
      end
    end
    return used < bank_pkg::Depth;
  endfunction

  task automatic update_model();
    logic ready;
    int   size;
    ready = model_ready();
    if (drv_in_valid && !ready) begin
      full_seen++;
    end
    size = model_q[drv_rel_id].size();
    // Releases of an empty ID are ignored
    if (drv_rel_valid && size != 0) begin
      if (drv_in_valid && ready && drv_id == drv_rel_id) begin
        same_cycle[size > 2 ? 2 : size - 1]++;
      end
      if (size > 1) begin
        ram_pops++;
      end
      void'(model_q[drv_rel_id].pop_front());
    end
    if (drv_in_valid && ready) begin
      model_q[drv_id].push_back(drv_payload);
    end
  endtask

  // Fill, drain and mixed phases in turn
  task automatic pick_stimulus(input int cyc);
    int phase;
    int in_pct;
    int rel_pct;
    phase = cyc % 400;
    if (cyc >= NumCycles) begin
      in_pct  = 0;
      rel_pct = 0;
    end else if (phase < 120) begin
      in_pct  = 90;
      rel_pct = 10;
    end else if (phase < 240) begin
      in_pct  = 5;
      rel_pct = 90;
    end else begin
      in_pct  = 50;
      rel_pct = 50;
    end
    drv_in_valid  = ($unsigned($random(seed)) % 100) < in_pct;
    drv_id        = bank_pkg::id_t'($random(seed));
    drv_payload   = msg_pkg::payload_t'($random(seed));
    drv_rel_valid = ($unsigned($random(seed)) % 100) < rel_pct;
    drv_rel_id    = bank_pkg::id_t'($random(seed));
  endtask

  task automatic check_outputs();
    check_value("in_ready_o", 32'(model_ready()), 32'(in_ready_o));
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      check_value($sformatf("buf_valid_o[%0d]", i), 32'(model_q[i].size() != 0),
                  32'(buf_valid_o[i]));
      if (model_q[i].size() != 0) begin
        check_value($sformatf("buf_data_o[%0d]", i), 32'(model_q[i][0]), 32'(buf_data_o[i]));
      end
    end
  endtask

  task automatic check_coverage();
    if (full_seen == 0) begin
      errors++;
      $display("Coverage hole: no input was offered while the RAM was full");
    end
    for (int k = 0; k < 3; k++) begin
      if (same_cycle[k] == 0) begin
        errors++;
        $display("Coverage hole: no input and release of one ID at list length class %0d", k);
      end
    end
    if (ram_pops <= bank_pkg::Depth) begin
      errors++;
      $display("Coverage hole: only %0d refills from the RAM, too few to reuse entries",
               ram_pops);
    end
  endtask

  initial begin
    rst_ni          = 1'b0;
    in_valid_i      = 1'b0;
    in_msg_i        = '0;
    release_valid_i = 1'b0;
    release_id_i    = '0;
    drv_in_valid    = 1'b0;
    drv_id          = '0;
    drv_payload     = '0;
    drv_rel_valid   = 1'b0;
    drv_rel_id      = '0;
    repeat (ResetCycles) begin
      @(negedge clk_i);
      check_value("buf_valid_o", 32'h0, 32'(buf_valid_o));
      check_value("in_ready_o", 32'h1, 32'(in_ready_o));
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    // One extra idle cycle lets the last stimulus be checked
    for (int cyc = 0; cyc <= NumCycles; cyc++) begin
      @(posedge clk_i);
      update_model();
      pick_stimulus(cyc);
      in_valid_i       <= drv_in_valid;
      in_msg_i.id      <= drv_id;
      in_msg_i.payload <= drv_payload;
      release_valid_i  <= drv_rel_valid;
      release_id_i     <= drv_rel_id;
      @(negedge clk_i);
      check_outputs();
    end
    check_coverage();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not end within %0d ns", TimeoutNs);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/msg_bank_props.sv
// ----------------------------------------------------------
// Concurrent assertions on the message bank top level,
// attached with bind
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module msg_bank_props (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        release_valid_i,
  input bank_pkg::id_t               release_id_i,
  input logic                        in_ready_o,
  input logic                        full_i,
  input logic [bank_pkg::NumIds-1:0] buf_valid_o
);

  // A buffer empties only after a release of its own ID
  for (genvar i = 0; i < bank_pkg::NumIds; i++) begin : g_valid
    a_valid_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $fell(buf_valid_o[i]) |->
        $past(release_valid_i && (release_id_i == bank_pkg::id_t'(i))))
      else $error("buf_valid_o[%0d] fell without a release of that ID", i);
  end

  a_ready_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> in_ready_o)
    else $error("in_ready_o low in the first cycle after reset");

  a_ready_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_o == !full_i)
    else $error("in_ready_o does not follow the allocator full flag");

endmodule

bind msg_bank_top msg_bank_props u_props (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .release_valid_i (release_valid_i),
  .release_id_i    (release_id_i),
  .in_ready_o      (in_ready_o),
  .full_i          (full),
  .buf_valid_o     (buf_valid_o)
);

`default_nettype wire

//--- logic/msg_bank_top.sv
// ----------------------------------------------------------
// Message bank top: allocator, entry RAM, list control
// and output buffers
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module msg_bank_top (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     in_valid_i,
  input  msg_pkg::msg_in_t                         in_msg_i,
  output logic                                     in_ready_o,
  input  logic                                     release_valid_i,
  input  bank_pkg::id_t                            release_id_i,
  output logic [bank_pkg::NumIds-1:0]              buf_valid_o,
  output msg_pkg::payload_t [bank_pkg::NumIds-1:0] buf_data_o
);

  bank_pkg::addr_t    free_addr;
  logic               full;
  logic               alloc;
  logic               release_en;
  bank_pkg::addr_t    release_addr;
  msg_pkg::msg_wr_t   msg_wr;
  bank_pkg::link_wr_t link_wr;
  logic               rd_en;
  bank_pkg::addr_t    rd_addr;
  msg_pkg::payload_t  rd_payload;
  bank_pkg::addr_t    rd_next;
  bank_pkg::buf_cmd_t buf_cmd;

  slot_alloc u_slot_alloc (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .alloc_i        (alloc),
    .release_en_i   (release_en),
    .release_addr_i (release_addr),
    .free_addr_o    (free_addr),
    .full_o         (full)
  );

  entry_ram u_entry_ram (
    .clk_i        (clk_i),
    .msg_wr_i     (msg_wr),
    .link_wr_i    (link_wr),
    .rd_en_i      (rd_en),
    .rd_addr_i    (rd_addr),
    .rd_payload_o (rd_payload),
    .rd_next_o    (rd_next)
  );

  list_ctrl u_list_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_valid_i      (in_valid_i),
    .in_msg_i        (in_msg_i),
    .in_ready_o      (in_ready_o),
    .release_valid_i (release_valid_i),
    .release_id_i    (release_id_i),
    .buf_valid_i     (buf_valid_o),
    .free_addr_i     (free_addr),
    .full_i          (full),
    .alloc_o         (alloc),
    .release_en_o    (release_en),
    .release_addr_o  (release_addr),
    .msg_wr_o        (msg_wr),
    .link_wr_o       (link_wr),
    .rd_en_o         (rd_en),
    .rd_addr_o       (rd_addr),
    .rd_next_i       (rd_next),
    .buf_cmd_o       (buf_cmd)
  );

  // Input payload reaches the buffers through the RAM write data
  out_buf u_out_buf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_cmd_i    (buf_cmd),
    .in_payload_i (msg_wr.data),
    .rd_payload_i (rd_payload),
    .buf_valid_o  (buf_valid_o),
    .buf_data_o   (buf_data_o)
  );

endmodule

`default_nettype wire

//--- list/out_buf.sv
// ----------------------------------------------------------
// Per-ID output buffers with valid bits and the refill
// path from the entry RAM read data
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module out_buf (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  bank_pkg::buf_cmd_t                       buf_cmd_i,
  input  msg_pkg::payload_t                        in_payload_i,
  input  msg_pkg::payload_t                        rd_payload_i,
  output logic [bank_pkg::NumIds-1:0]              buf_valid_o,
  output msg_pkg::payload_t [bank_pkg::NumIds-1:0] buf_data_o
);

  msg_pkg::payload_t [bank_pkg::NumIds-1:0] data_q;
  msg_pkg::payload_t [bank_pkg::NumIds-1:0] data_d;
  logic [bank_pkg::NumIds-1:0]              valid_q;
  logic [bank_pkg::NumIds-1:0]              valid_d;
  logic [bank_pkg::NumIds-1:0]              refill_q;
  logic [bank_pkg::NumIds-1:0]              refill_d;

  // RAM data is shown for one cycle, then kept in the register
  always_comb begin
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      buf_data_o[i] = refill_q[i] ? rd_payload_i : data_q[i];
    end
  end

  assign buf_valid_o = valid_q;

  always_comb begin
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      data_d[i]   = buf_data_o[i];
      valid_d[i]  = valid_q[i];
      refill_d[i] = 1'b0;
      case (buf_cmd_i[i])
        bank_pkg::BUF_LOAD_IN: begin
          data_d[i]  = in_payload_i;
          valid_d[i] = 1'b1;
        end
        bank_pkg::BUF_LOAD_RAM: begin
          refill_d[i] = 1'b1;
          valid_d[i]  = 1'b1;
        end
        bank_pkg::BUF_CLEAR: begin
          valid_d[i] = 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      refill_q <= '0;
    end else begin
      valid_q  <= valid_d;
      refill_q <= refill_d;
    end
  end

endmodule

`default_nettype wire

//--- list/list_ctrl.sv
// ----------------------------------------------------------
// Per-ID linked list control: head, tail and length
// registers, input acceptance and release handling
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module list_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        in_valid_i,
  input  msg_pkg::msg_in_t            in_msg_i,
  output logic                        in_ready_o,
  input  logic                        release_valid_i,
  input  bank_pkg::id_t               release_id_i,
  input  logic [bank_pkg::NumIds-1:0] buf_valid_i,
  input  bank_pkg::addr_t             free_addr_i,
  input  logic                        full_i,
  output logic                        alloc_o,
  output logic                        release_en_o,
  output bank_pkg::addr_t             release_addr_o,
  output msg_pkg::msg_wr_t            msg_wr_o,
  output bank_pkg::link_wr_t          link_wr_o,
  output logic                        rd_en_o,
  output bank_pkg::addr_t             rd_addr_o,
  input  bank_pkg::addr_t             rd_next_i,
  output bank_pkg::buf_cmd_t          buf_cmd_o
);

  bank_pkg::addr_t head_q   [bank_pkg::NumIds];
  bank_pkg::addr_t head_d   [bank_pkg::NumIds];
  bank_pkg::addr_t head_now [bank_pkg::NumIds];
  bank_pkg::addr_t tail_q   [bank_pkg::NumIds];
  bank_pkg::addr_t tail_d   [bank_pkg::NumIds];
  bank_pkg::len_t  len_q    [bank_pkg::NumIds];
  bank_pkg::len_t  len_d    [bank_pkg::NumIds];

  logic [bank_pkg::NumIds-1:0] from_ram_q;
  logic [bank_pkg::NumIds-1:0] from_ram_d;
  logic [bank_pkg::NumIds-1:0] in_hit;
  logic [bank_pkg::NumIds-1:0] rel_hit;
  logic [bank_pkg::NumIds-1:0] pop;
  logic [bank_pkg::NumIds-1:0] append;
  logic [bank_pkg::NumIds-1:0] restart;
  logic                        accept;

  // Inputs wait while every entry is taken, even for an empty buffer
  assign in_ready_o = !full_i;
  assign accept     = in_valid_i && in_ready_o;

  always_comb begin
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      // Head arrives from the RAM one cycle after a pop
      head_now[i] = from_ram_q[i] ? rd_next_i : head_q[i];
      in_hit[i]   = accept && (in_msg_i.id == bank_pkg::id_t'(i));
      rel_hit[i]  = release_valid_i && (release_id_i == bank_pkg::id_t'(i)) && buf_valid_i[i];
      pop[i]      = rel_hit[i] && (len_q[i] != '0);
      append[i]   = in_hit[i] && buf_valid_i[i] && !(rel_hit[i] && (len_q[i] == '0));
      // New list when empty, or when its only entry leaves now
      restart[i]  = append[i] &&
                    ((len_q[i] == '0) || ((len_q[i] == bank_pkg::len_t'(1)) && pop[i]));
    end
  end

  always_comb begin
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      if (in_hit[i] && (!buf_valid_i[i] || (rel_hit[i] && (len_q[i] == '0)))) begin
        buf_cmd_o[i] = bank_pkg::BUF_LOAD_IN;
      end else if (pop[i]) begin
        buf_cmd_o[i] = bank_pkg::BUF_LOAD_RAM;
      end else if (rel_hit[i]) begin
        buf_cmd_o[i] = bank_pkg::BUF_CLEAR;
      end else begin
        buf_cmd_o[i] = bank_pkg::BUF_HOLD;
      end
    end
  end

  // One input per cycle, so at most one ID appends
  always_comb begin
    alloc_o       = 1'b0;
    link_wr_o     = '0;
    msg_wr_o.en   = 1'b0;
    msg_wr_o.addr = free_addr_i;
    msg_wr_o.data = in_msg_i.payload;
    for (int i = 0; i < bank_pkg::NumIds; i++) begin
      head_d[i]     = head_now[i];
      tail_d[i]     = tail_q[i];
      len_d[i]      = len_q[i];
      from_ram_d[i] = pop[i] && (len_q[i] > bank_pkg::len_t'(1));
      if (pop[i]) begin
        len_d[i] = len_d[i] - bank_pkg::len_t'(1);
      end
      if (append[i]) begin
        alloc_o     = 1'b1;
        msg_wr_o.en = 1'b1;
        len_d[i]    = len_d[i] + bank_pkg::len_t'(1);
        tail_d[i]   = free_addr_i;
        if (restart[i]) begin
          head_d[i] = free_addr_i;
        end else begin
          link_wr_o.en   = 1'b1;
          link_wr_o.addr = tail_q[i];
          link_wr_o.data = free_addr_i;
        end
      end
    end
  end

  // Popped head is read and freed in the same cycle
  assign rd_en_o        = |pop;
  assign rd_addr_o      = head_now[release_id_i];
  assign release_en_o   = rd_en_o;
  assign release_addr_o = rd_addr_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      from_ram_q <= '0;
      for (int i = 0; i < bank_pkg::NumIds; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        len_q[i]  <= '0;
      end
    end else begin
      from_ram_q <= from_ram_d;
      for (int i = 0; i < bank_pkg::NumIds; i++) begin
        head_q[i] <= head_d[i];
        tail_q[i] <= tail_d[i];
        len_q[i]  <= len_d[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/entry_ram.sv
// ----------------------------------------------------------
// Entry RAM: payload and next-pointer arrays, one write port
// each, one shared registered read port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module entry_ram (
  input  logic               clk_i,
  input  msg_pkg::msg_wr_t   msg_wr_i,
  input  bank_pkg::link_wr_t link_wr_i,
  input  logic               rd_en_i,
  input  bank_pkg::addr_t    rd_addr_i,
  output msg_pkg::payload_t  rd_payload_o,
  output bank_pkg::addr_t    rd_next_o
);

  msg_pkg::payload_t payload_mem [bank_pkg::Depth];
  bank_pkg::addr_t   next_mem    [bank_pkg::Depth];

  // Payload of a newly allocated entry
  always_ff @(posedge clk_i) begin
    if (msg_wr_i.en) begin
      payload_mem[msg_wr_i.addr] <= msg_wr_i.data;
    end
  end

  // Link from the old tail to the new entry
  always_ff @(posedge clk_i) begin
    if (link_wr_i.en) begin
      next_mem[link_wr_i.addr] <= link_wr_i.data;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_payload_o <= payload_mem[rd_addr_i];
      rd_next_o    <= next_mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- logic/slot_alloc.sv
// ----------------------------------------------------------
// Entry allocator: used-entry bitmap, lowest free entry
// finder and full flag
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slot_alloc (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            alloc_i,
  input  logic            release_en_i,
  input  bank_pkg::addr_t release_addr_i,
  output bank_pkg::addr_t free_addr_o,
  output logic            full_o
);

  logic [bank_pkg::Depth-1:0] used_q;
  logic [bank_pkg::Depth-1:0] used_d;

  // Priority encoder, lowest index wins
  always_comb begin
    free_addr_o = '0;
    for (int i = bank_pkg::Depth - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        free_addr_o = bank_pkg::addr_t'(i);
      end
    end
  end

  assign full_o = &used_q;

  // Released entry is always a used one, so it never collides with the free one
  always_comb begin
    used_d = used_q;
    if (release_en_i) begin
      used_d[release_addr_i] = 1'b0;
    end
    if (alloc_i) begin
      used_d[free_addr_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

`default_nettype wire

//--- common/msg_pkg.sv
// ----------------------------------------------------------
// Message format: payload type, tagged input message and
// the payload write into the entry RAM
// ----------------------------------------------------------
`default_nettype none

package msg_pkg;

  localparam int PayloadWidth = 16;

  typedef logic [PayloadWidth-1:0] payload_t;

  typedef struct packed {
    bank_pkg::id_t id;
    payload_t      payload;
  } msg_in_t;

  // Payload write at a newly allocated entry
  typedef struct packed {
    logic            en;
    bank_pkg::addr_t addr;
    payload_t        data;
  } msg_wr_t;

endpackage

`default_nettype wire

//--- common/bank_pkg.sv
// ----------------------------------------------------------
// Storage geometry of the message bank: sizes, index types,
// the next-pointer write and the per-ID buffer commands
// ----------------------------------------------------------
`default_nettype none

package bank_pkg;

  localparam int NumIds    = 4;
  localparam int IdWidth   = $clog2(NumIds);
  localparam int Depth     = 16;
  localparam int AddrWidth = $clog2(Depth);
  // One extra bit so a list can hold every entry
  localparam int LenWidth  = $clog2(Depth + 1);

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [LenWidth-1:0]  len_t;

  // Next-pointer write into the link array
  typedef struct packed {
    logic  en;
    addr_t addr;
    addr_t data;
  } link_wr_t;

  typedef enum logic [1:0] {
    BUF_HOLD     = 2'd0,
    BUF_LOAD_IN  = 2'd1,
    BUF_LOAD_RAM = 2'd2,
    BUF_CLEAR    = 2'd3
  } buf_op_e;

  typedef buf_op_e [NumIds-1:0] buf_cmd_t;

endpackage

`default_nettype wire
